//--- core_settings.svh
// Core-wide widths and reset program counter for the pipelined integer core
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and instruction word
`define CORE_WORD_WIDTH 32

// Index into the 32-entry register file
`define CORE_REG_ADDR_WIDTH 5

// Word address fetched first after reset
`define CORE_RESET_PC 0

`endif

//--- isaPkg.sv
// Instruction-set encodings: opcodes, ALU operations and instruction field positions
package isaPkg;

    // Major opcode, bits 31..27
    typedef enum logic [4:0] {
        opRType = 5'd0,
        opJump  = 5'd1,
        opBne   = 5'd2,
        opAddi  = 5'd5,
        opBlt   = 5'd6,
        opSw    = 5'd7,
        opLw    = 5'd8
    } opcodeT;

    // R-type function field, bits 6..2
    typedef enum logic [4:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOpT;

    localparam int opHi     = 31;
    localparam int opLo     = 27;
    localparam int rdHi     = 26;
    localparam int rdLo     = 22;
    localparam int rsHi     = 21;
    localparam int rsLo     = 17;
    localparam int rtHi     = 16;
    localparam int rtLo     = 12;
    localparam int shamtHi  = 11;
    localparam int shamtLo  = 7;
    localparam int aluHi    = 6;
    localparam int aluLo    = 2;
    localparam int immHi    = 16;   // Sign bit of the immediate
    localparam int immLo    = 0;
    localparam int targetHi = 26;   // Jump target, zero-extended
    localparam int targetLo = 0;

endpackage

//--- pipePkg.sv
// Pipeline control types and the register-usage decode shared by every stage
`include "core_settings.svh"

package pipePkg;
    import isaPkg::*;

    typedef enum logic [2:0] {
        aluReg,
        aluImm,
        store,
        load,
        branch,
        jump,
        none
    } insClassT;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        fromLatch,
        fromMemory,
        fromWriteback
    } operandSrcT;

    function automatic insClassT classOf(input logic [`CORE_WORD_WIDTH-1:0] ir);
        case (ir[opHi:opLo])
            opRType: return aluReg;
            opAddi:  return aluImm;
            opSw:    return store;
            opLw:    return load;
            opBne,
            opBlt:   return branch;
            opJump:  return jump;
            default: return none;     // Unknown opcodes behave as no-ops
        endcase
    endfunction

    // First source register, zero when unused
    function automatic logic [`CORE_REG_ADDR_WIDTH-1:0] readA(
        input logic [`CORE_WORD_WIDTH-1:0] ir
    );
        case (classOf(ir))
            aluReg, aluImm, load, store: return ir[rsHi:rsLo];
            branch:                      return ir[rdHi:rdLo];
            default:                     return '0;
        endcase
    endfunction

    // Second source register; store data sits in rd, branches compare rd against rs
    function automatic logic [`CORE_REG_ADDR_WIDTH-1:0] readB(
        input logic [`CORE_WORD_WIDTH-1:0] ir
    );
        case (classOf(ir))
            aluReg:  return ir[rtHi:rtLo];
            store:   return ir[rdHi:rdLo];
            branch:  return ir[rsHi:rsLo];
            default: return '0;
        endcase
    endfunction

    // Destination register, zero for anything that writes nothing
    function automatic logic [`CORE_REG_ADDR_WIDTH-1:0] writeReg(
        input logic [`CORE_WORD_WIDTH-1:0] ir
    );
        case (classOf(ir))
            aluReg, aluImm, load: return ir[rdHi:rdLo];
            default:              return '0;
        endcase
    endfunction

endpackage

//--- fetchUnit.sv
// Fetch stage with the program counter, next-PC choice and fetch/decode register
`timescale 1ns/1ps
`include "core_settings.svh"

module fetchUnit (
    input  logic                        clock,
    input  logic                        rstN,
    input  logic                        interlockStall, // Load-use hold
    input  logic                        branchTaken,    // Redirect from execute
    input  logic [`CORE_WORD_WIDTH-1:0] branchTarget,
    input  logic [`CORE_WORD_WIDTH-1:0] qImem,
    output logic [`CORE_WORD_WIDTH-1:0] addressImem,
    output logic [`CORE_WORD_WIDTH-1:0] decodeIr,
    output logic [`CORE_WORD_WIDTH-1:0] decodePc
);

    logic [`CORE_WORD_WIDTH-1:0] pc;
    logic [`CORE_WORD_WIDTH-1:0] nextPc;

    // Redirect beats the interlock, the PC counts words
    always_comb begin
        if (branchTaken)
            nextPc = branchTarget;
        else if (interlockStall)
            nextPc = pc;
        else
            nextPc = pc + 1'b1;
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN)
            pc <= `CORE_WORD_WIDTH'(`CORE_RESET_PC);
        else
            pc <= nextPc;
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN)
            decodeIr <= '0;
        else if (branchTaken)
            decodeIr <= '0;             // Squash wrong-path fetch
        else if (!interlockStall)
            decodeIr <= qImem;
    end

    always_ff @(posedge clock) begin
        if (!interlockStall)
            decodePc <= pc;             // Own address, for branch targets
    end

    assign addressImem = pc;

endmodule

//--- decodeUnit.sv
// Decode stage reading the register file and loading the decode/execute register
`timescale 1ns/1ps
`include "core_settings.svh"

module decodeUnit import pipePkg::*; (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic [`CORE_WORD_WIDTH-1:0]     decodeIr,
    input  logic [`CORE_WORD_WIDTH-1:0]     decodePc,
    input  logic                            interlockStall,
    input  logic                            branchTaken,
    input  logic [`CORE_WORD_WIDTH-1:0]     dataReadRegA,
    input  logic [`CORE_WORD_WIDTH-1:0]     dataReadRegB,
    input  logic                            forwardA,     // Writeback hits read port A
    input  logic                            forwardB,
    input  logic [`CORE_WORD_WIDTH-1:0]     dataWriteReg,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] ctrlReadRegA,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] ctrlReadRegB,
    output logic [`CORE_WORD_WIDTH-1:0]     executeIr,
    output logic [`CORE_WORD_WIDTH-1:0]     executePc,
    output logic [`CORE_WORD_WIDTH-1:0]     executeA,
    output logic [`CORE_WORD_WIDTH-1:0]     executeB
);

    logic [`CORE_WORD_WIDTH-1:0] operandA;
    logic [`CORE_WORD_WIDTH-1:0] operandB;
    logic                        bubble;

    // rs or rd on A, rt or rd or rs on B, by class
    assign ctrlReadRegA = readA(decodeIr);
    assign ctrlReadRegB = readB(decodeIr);

    // Register file writes at the same edge, so take the value early
    assign operandA = forwardA ? dataWriteReg : dataReadRegA;
    assign operandB = forwardB ? dataWriteReg : dataReadRegB;

    assign bubble = interlockStall || branchTaken;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN)
            executeIr <= '0;
        else if (bubble)
            executeIr <= '0;            // No-op into execute
        else
            executeIr <= decodeIr;
    end

    // Operands ride along even under a bubble, the no-op ignores them
    always_ff @(posedge clock) begin
        executePc <= decodePc;
        executeA  <= operandA;
        executeB  <= operandB;
    end

endmodule

//--- hazardUnit.sv
// Hazard detection: load-use interlock, execute bypass selects and decode forwarding
`timescale 1ns/1ps
`include "core_settings.svh"

module hazardUnit import pipePkg::*; (
    input  logic [`CORE_WORD_WIDTH-1:0] decodeIr,
    input  logic [`CORE_WORD_WIDTH-1:0] executeIr,
    input  logic [`CORE_WORD_WIDTH-1:0] memoryIr,
    input  logic [`CORE_WORD_WIDTH-1:0] writebackIr,
    output logic                        interlockStall,
    output operandSrcT                  aSrc,
    output operandSrcT                  bSrc,
    output logic                        storeBypass,
    output logic                        forwardA,
    output logic                        forwardB
);

    logic [`CORE_REG_ADDR_WIDTH-1:0] memoryDest;
    logic [`CORE_REG_ADDR_WIDTH-1:0] writebackDest;
    logic [`CORE_REG_ADDR_WIDTH-1:0] loadDest;

    // Register 0 never matches
    function automatic logic hit(
        input logic [`CORE_REG_ADDR_WIDTH-1:0] src,
        input logic [`CORE_REG_ADDR_WIDTH-1:0] dest
    );
        return (src != '0) && (src == dest);
    endfunction

    function automatic operandSrcT pick(input logic [`CORE_REG_ADDR_WIDTH-1:0] src);
        if (hit(src, memoryDest))
            return fromMemory;          // Youngest value wins
        else if (hit(src, writebackDest))
            return fromWriteback;
        else
            return fromLatch;
    endfunction

    // A load in memory has only its address, so only ALU results bypass from there
    assign memoryDest    = (classOf(memoryIr) inside {aluReg, aluImm}) ? writeReg(memoryIr) : '0;
    assign writebackDest = writeReg(writebackIr);
    assign loadDest      = (classOf(executeIr) == load) ? writeReg(executeIr) : '0;

    assign aSrc = pick(readA(executeIr));
    assign bSrc = pick(readB(executeIr));

    // Store data from a load is patched later in memory instead of stalling
    assign interlockStall = hit(readA(decodeIr), loadDest) ||
                            (classOf(decodeIr) != store && hit(readB(decodeIr), loadDest));

    assign storeBypass = (classOf(memoryIr) == store) && hit(readB(memoryIr), writebackDest);

    assign forwardA = hit(readA(decodeIr), writebackDest);
    assign forwardB = hit(readB(decodeIr), writebackDest);

endmodule

//--- executeUnit.sv
// Execute stage with operand bypass, ALU, branch resolution and execute/memory register
`timescale 1ns/1ps
`include "core_settings.svh"

module executeUnit import isaPkg::*; import pipePkg::*; (
    input  logic                        clock,
    input  logic                        rstN,
    input  logic [`CORE_WORD_WIDTH-1:0] executeIr,
    input  logic [`CORE_WORD_WIDTH-1:0] executePc,
    input  logic [`CORE_WORD_WIDTH-1:0] executeA,
    input  logic [`CORE_WORD_WIDTH-1:0] executeB,
    input  operandSrcT                  aSrc,
    input  operandSrcT                  bSrc,
    input  logic [`CORE_WORD_WIDTH-1:0] dataWriteReg,   // Writeback bypass value
    output logic                        branchTaken,
    output logic [`CORE_WORD_WIDTH-1:0] branchTarget,
    output logic [`CORE_WORD_WIDTH-1:0] memoryIr,
    output logic [`CORE_WORD_WIDTH-1:0] memoryResult,   // Also the memory bypass value
    output logic [`CORE_WORD_WIDTH-1:0] memoryStore
);

    insClassT                    insClass;
    aluOpT                       aluOp;
    logic [`CORE_WORD_WIDTH-1:0] opA;
    logic [`CORE_WORD_WIDTH-1:0] opB;
    logic [`CORE_WORD_WIDTH-1:0] aluB;
    logic [`CORE_WORD_WIDTH-1:0] imm;
    logic [`CORE_WORD_WIDTH-1:0] result;
    logic [shamtHi-shamtLo:0]    shamt;

    assign insClass = classOf(executeIr);
    assign imm      = {{(`CORE_WORD_WIDTH-immHi-1){executeIr[immHi]}}, executeIr[immHi:immLo]};
    assign shamt    = executeIr[shamtHi:shamtLo];

    // Bypass muxes
    always_comb begin
        case (aSrc)
            fromMemory:    opA = memoryResult;
            fromWriteback: opA = dataWriteReg;
            default:       opA = executeA;
        endcase
        case (bSrc)
            fromMemory:    opB = memoryResult;
            fromWriteback: opB = dataWriteReg;
            default:       opB = executeB;
        endcase
    end

    // addi, lw and sw all add the immediate
    assign aluB  = (insClass inside {aluImm, load, store}) ? imm : opB;
    assign aluOp = (insClass == aluReg) ? aluOpT'(executeIr[aluHi:aluLo]) : aluAdd;

    always_comb begin
        case (aluOp)
            aluSub:  result = opA - aluB;
            aluAnd:  result = opA & aluB;
            aluOr:   result = opA | aluB;
            aluSll:  result = opA << shamt;
            aluSra:  result = $signed(opA) >>> shamt;   // Sign fill
            default: result = opA + aluB;
        endcase
    end

    // bne and blt compare rd (A) with rs (B)
    always_comb begin
        case (insClass)
            jump:    branchTaken = 1'b1;
            branch:  branchTaken = (executeIr[opHi:opLo] == opBne) ? (opA != opB)
                                                                 : ($signed(opA) < $signed(opB));
            default: branchTaken = 1'b0;
        endcase
    end

    assign branchTarget = (insClass == jump)
                        ? {{(`CORE_WORD_WIDTH-targetHi-1){1'b0}}, executeIr[targetHi:targetLo]}
                        : executePc + imm + 1'b1;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN)
            memoryIr <= '0;
        else
            memoryIr <= executeIr;
    end

    always_ff @(posedge clock) begin
        memoryResult <= result;
        memoryStore  <= opB;            // Bypassed store data, never the immediate
    end

endmodule

//--- resultUnit.sv
// Memory and writeback stages: data memory drive, memory/writeback register, register write
`timescale 1ns/1ps
`include "core_settings.svh"

module resultUnit import pipePkg::*; (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic [`CORE_WORD_WIDTH-1:0]     memoryIr,
    input  logic [`CORE_WORD_WIDTH-1:0]     memoryResult,
    input  logic [`CORE_WORD_WIDTH-1:0]     memoryStore,
    input  logic                            storeBypass,
    input  logic [`CORE_WORD_WIDTH-1:0]     qDmem,
    output logic [`CORE_WORD_WIDTH-1:0]     addressDmem,
    output logic [`CORE_WORD_WIDTH-1:0]     data,
    output logic                            wren,
    output logic [`CORE_WORD_WIDTH-1:0]     writebackIr,
    output logic                            ctrlWriteEnable,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] ctrlWriteReg,
    output logic [`CORE_WORD_WIDTH-1:0]     dataWriteReg
);

    logic [`CORE_REG_ADDR_WIDTH-1:0] writebackDest;

    // ALU result is the address for lw and sw
    assign addressDmem = memoryResult;
    assign data        = storeBypass ? dataWriteReg : memoryStore;  // Load right before a store
    assign wren        = classOf(memoryIr) == store;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN)
            writebackIr <= '0;
        else
            writebackIr <= memoryIr;
    end

    // Result chosen at the edge, so writeback carries one word
    always_ff @(posedge clock) begin
        dataWriteReg <= (classOf(memoryIr) == load) ? qDmem : memoryResult;
    end

    assign writebackDest   = writeReg(writebackIr);
    assign ctrlWriteEnable = writebackDest != '0;       // r0 stays zero
    assign ctrlWriteReg    = writebackDest;

endmodule

//--- pipelineCore.sv
// Five-stage pipelined integer core wired to external memories and register file
`timescale 1ns/1ps
`include "core_settings.svh"

module pipelineCore import pipePkg::*; (
    input  logic                            clock,
    input  logic                            rstN,
    // Instruction memory
    output logic [`CORE_WORD_WIDTH-1:0]     addressImem,
    input  logic [`CORE_WORD_WIDTH-1:0]     qImem,
    // Data memory
    output logic [`CORE_WORD_WIDTH-1:0]     addressDmem,
    output logic [`CORE_WORD_WIDTH-1:0]     data,
    output logic                            wren,
    input  logic [`CORE_WORD_WIDTH-1:0]     qDmem,
    // Register file
    output logic                            ctrlWriteEnable,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] ctrlWriteReg,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] ctrlReadRegA,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] ctrlReadRegB,
    output logic [`CORE_WORD_WIDTH-1:0]     dataWriteReg,
    input  logic [`CORE_WORD_WIDTH-1:0]     dataReadRegA,
    input  logic [`CORE_WORD_WIDTH-1:0]     dataReadRegB
);

    logic [`CORE_WORD_WIDTH-1:0] decodeIr, decodePc;
    logic [`CORE_WORD_WIDTH-1:0] executeIr, executePc, executeA, executeB;
    logic [`CORE_WORD_WIDTH-1:0] memoryIr, memoryResult, memoryStore;
    logic [`CORE_WORD_WIDTH-1:0] writebackIr;
    logic [`CORE_WORD_WIDTH-1:0] branchTarget;
    logic                        branchTaken;
    logic                        interlockStall, storeBypass;
    logic                        forwardA, forwardB;
    operandSrcT                  aSrc, bSrc;

    fetchUnit fetchUnit_inst (
        .clock, .rstN, .interlockStall, .branchTaken, .branchTarget,
        .qImem, .addressImem, .decodeIr, .decodePc
    );

    decodeUnit decodeUnit_inst (
        .clock, .rstN, .decodeIr, .decodePc, .interlockStall, .branchTaken,
        .dataReadRegA, .dataReadRegB, .forwardA, .forwardB, .dataWriteReg,
        .ctrlReadRegA, .ctrlReadRegB, .executeIr, .executePc, .executeA, .executeB
    );

    hazardUnit hazardUnit_inst (
        .decodeIr, .executeIr, .memoryIr, .writebackIr,
        .interlockStall, .aSrc, .bSrc, .storeBypass, .forwardA, .forwardB
    );

    executeUnit executeUnit_inst (
        .clock, .rstN, .executeIr, .executePc, .executeA, .executeB,
        .aSrc, .bSrc, .dataWriteReg,
        .branchTaken, .branchTarget, .memoryIr, .memoryResult, .memoryStore
    );

    resultUnit resultUnit_inst (
        .clock, .rstN, .memoryIr, .memoryResult, .memoryStore, .storeBypass, .qDmem,
        .addressDmem, .data, .wren, .writebackIr,
        .ctrlWriteEnable, .ctrlWriteReg, .dataWriteReg
    );

endmodule

//--- tbPipelineCore.sv
// Testbench for the pipelined core with memory, register-file and instruction-set models
`timescale 1ns/1ps
`include "core_settings.svh"

module tbPipelineCore import isaPkg::*; ();

    localparam int imemDepth = 256;

    logic                            clock;
    logic                            rstN;
    logic [`CORE_WORD_WIDTH-1:0]     addressImem, qImem;
    logic [`CORE_WORD_WIDTH-1:0]     addressDmem, data, qDmem;
    logic                            wren;
    logic                            ctrlWriteEnable;
    logic [`CORE_REG_ADDR_WIDTH-1:0] ctrlWriteReg, ctrlReadRegA, ctrlReadRegB;
    logic [`CORE_WORD_WIDTH-1:0]     dataWriteReg, dataReadRegA, dataReadRegB;

    logic [`CORE_WORD_WIDTH-1:0]     imem [0:imemDepth-1];
    logic [`CORE_WORD_WIDTH-1:0]     dmem [0:63];
    logic [`CORE_WORD_WIDTH-1:0]     regs [0:31];
    logic [`CORE_WORD_WIDTH-1:0]     modelRegs [0:31];
    logic [`CORE_WORD_WIDTH-1:0]     modelMem [0:63];

    // Expected writes and stores, in program order
    logic [`CORE_REG_ADDR_WIDTH-1:0] expWriteReg [$];
    logic [`CORE_WORD_WIDTH-1:0]     expWriteData [$];
    logic [`CORE_WORD_WIDTH-1:0]     expStoreAddr [$];
    logic [`CORE_WORD_WIDTH-1:0]     expStoreData [$];

    int progLen = 0;
    int expWrites = 0;
    int expStores = 0;
    int writesSeen = 0;
    int storesSeen = 0;
    int errorCount = 0;
    int postResetCycles;
    bit programReady = 1'b0;

    pipelineCore pipelineCore_inst (.*);

    always #50 clock = ~clock;

    function automatic logic [31:0] fillWord(int addr);
        return 32'hC0DE_0000 ^ (32'(addr) * 32'h0001_0103);   // Distinct per address
    endfunction

    function automatic logic [31:0] rWord(aluOpT fn, int rd, int rs, int rt, int sh);
        return {opRType, 5'(rd), 5'(rs), 5'(rt), 5'(sh), fn, 2'b00};
    endfunction

    // rd is store data or first branch operand
    function automatic logic [31:0] immWord(opcodeT op, int rd, int rs, int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic logic [31:0] jumpWord(int target);
        return {opJump, 27'(target)};
    endfunction

    function automatic int pickReg();
        return 1 + int'($urandom % 31);           // Never r0
    endfunction

    task automatic emit(logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    // Hazard fragments with random registers and immediates
    task automatic buildProgram();
        int a, b, c, d, e, f;
        a = pickReg();
        b = pickReg();
        c = pickReg();
        d = pickReg();
        e = pickReg();
        f = (e % 31) + 1;                         // Distinct from e
        emit(immWord(opAddi, a, 0, int'($urandom % 2000) - 1000));
        emit(immWord(opAddi, b, a, int'($urandom % 2000) - 1000));  // Memory bypass
        emit(rWord(aluAdd, c, a, b, 0));          // Writeback and memory bypass
        emit(rWord(aluSub, d, c, a, 0));
        emit(rWord(aluAnd, a, d, c, 0));
        emit(rWord(aluOr, b, a, d, 0));
        emit(rWord(aluSll, c, b, 0, int'($urandom % 32)));
        emit(rWord(aluSra, d, c, 0, int'($urandom % 32)));
        emit(immWord(opAddi, 0, d, 7));           // r0 target, no write
        emit(immWord(opSw, d, 0, int'($urandom % 64)));
        emit(immWord(opLw, a, 0, int'($urandom % 64)));
        emit(rWord(aluAdd, b, a, a, 0));          // Load-use interlock
        emit(immWord(opLw, c, 0, int'($urandom % 64)));
        emit(immWord(opSw, c, 0, int'($urandom % 64)));  // Store-data bypass
        emit(rWord(aluOr, d, c, b, 0));
        emit(immWord(opAddi, e, 0, -5));
        emit(immWord(opAddi, f, 0, 9));
        emit(immWord(opBne, a, a, 2));            // Equal, falls through
        emit(immWord(opAddi, b, b, 1));
        emit(immWord(opAddi, c, c, 1));
        emit(immWord(opBne, e, f, 2));            // Taken
        emit(immWord(opAddi, a, a, 100));         // Flushed pair
        emit(immWord(opSw, b, 0, 63));
        emit(immWord(opBlt, e, f, 2));            // -5 < 9, taken
        emit(immWord(opAddi, c, c, 100));
        emit(immWord(opSw, c, 0, 62));
        emit(immWord(opBlt, f, e, 2));            // Not taken
        emit(immWord(opAddi, b, b, 3));
        emit(immWord(opAddi, c, c, 3));
        emit(jumpWord(progLen + 3));
        emit(immWord(opAddi, d, d, 100));
        emit(immWord(opSw, d, 0, 61));
        emit(rWord(aluAdd, a, b, c, 0));
        emit(immWord(opSw, a, 0, int'($urandom % 64)));
    endtask

    // In-order reference, one instruction per step
    task automatic runModel();
        logic [31:0] ir, rsVal, rtVal, rdVal, imm, addr, res;
        logic        writes;
        int          pc;
        int          steps;
        pc = 0;
        steps = 0;
        while (pc < progLen && steps < 1000) begin
            ir     = imem[pc];
            rsVal  = modelRegs[ir[rsHi:rsLo]];
            rtVal  = modelRegs[ir[rtHi:rtLo]];
            rdVal  = modelRegs[ir[rdHi:rdLo]];
            imm    = {{15{ir[immHi]}}, ir[immHi:immLo]};
            addr   = rsVal + imm;
            writes = 1'b0;
            res    = '0;
            pc++;                                 // Branch offsets count from here
            steps++;
            case (ir[opHi:opLo])
                opRType: begin
                    writes = 1'b1;
                    case (ir[aluHi:aluLo])
                        aluAdd:  res = rsVal + rtVal;
                        aluSub:  res = rsVal - rtVal;
                        aluAnd:  res = rsVal & rtVal;
                        aluOr:   res = rsVal | rtVal;
                        aluSll:  res = rsVal << ir[shamtHi:shamtLo];
                        aluSra:  res = $signed(rsVal) >>> ir[shamtHi:shamtLo];
                        default: writes = 1'b0;
                    endcase
                end
                opAddi: begin
                    writes = 1'b1;
                    res = addr;
                end
                opLw: begin
                    writes = 1'b1;
                    res = modelMem[addr[5:0]];
                end
                opSw: begin
                    expStoreAddr.push_back(addr);
                    expStoreData.push_back(rdVal);
                    modelMem[addr[5:0]] = rdVal;
                end
                opBne:   if (rdVal != rsVal) pc = pc + int'($signed(imm));
                opBlt:   if ($signed(rdVal) < $signed(rsVal)) pc = pc + int'($signed(imm));
                opJump:  pc = int'(ir[targetHi:targetLo]);
                default: ;
            endcase
            if (writes && ir[rdHi:rdLo] != '0) begin
                expWriteReg.push_back(ir[rdHi:rdLo]);
                expWriteData.push_back(res);
                modelRegs[ir[rdHi:rdLo]] = res;
            end
        end
    endtask

    // Combinational memories, sampled once addresses settle
    task automatic driveReads();
        qImem        = (addressImem < imemDepth) ? imem[addressImem[7:0]] : '0;
        qDmem        = dmem[addressDmem[5:0]];
        dataReadRegA = regs[ctrlReadRegA];
        dataReadRegB = regs[ctrlReadRegB];
    endtask

    always @(posedge clock) begin
        #5;
        driveReads();
    end

    always @(posedge clock) begin
        if (wren)
            dmem[addressDmem[5:0]] <= data;
        if (ctrlWriteEnable && ctrlWriteReg != '0)
            regs[ctrlWriteReg] <= dataWriteReg;
    end

    always @(posedge clock or negedge rstN) begin
        if (!rstN)
            postResetCycles <= 0;
        else if (postResetCycles < 8)
            postResetCycles <= postResetCycles + 1;
    end

    assert property (@(negedge clock) !(ctrlWriteEnable && ctrlWriteReg == '0))
        else begin
            errorCount++;
            $display("** Error at %0t: register write enabled for r0", $time);
        end

    assert property (@(negedge clock) !rstN |->
                     (!wren && !ctrlWriteEnable
                      && addressImem == `CORE_WORD_WIDTH'(`CORE_RESET_PC)))
        else begin
            errorCount++;
            $display("** Error at %0t: write or wrong PC during reset", $time);
        end

    always @(negedge clock) begin
        if (rstN && postResetCycles == 0)
            assert (addressImem == `CORE_WORD_WIDTH'(`CORE_RESET_PC)) else begin
                errorCount++;
                $display("** Error at %0t: first fetch address %h", $time, addressImem);
            end
        if (rstN && postResetCycles < 3)
            assert (!wren && !ctrlWriteEnable) else begin
                errorCount++;
                $display("** Error at %0t: write while the pipeline fills", $time);
            end
        if (rstN && ctrlWriteEnable) begin
            assert (writesSeen < expWrites) else begin
                errorCount++;
                $display("Register write to r%0d at %0t is beyond the expected sequence",
                         ctrlWriteReg, $time);
            end
            if (writesSeen < expWrites)
                assert (ctrlWriteReg == expWriteReg[writesSeen]
                        && dataWriteReg == expWriteData[writesSeen]) else begin
                    errorCount++;
                    $display("** Error at %0t: write %0d r%0d=%h, expected r%0d=%h", $time,
                             writesSeen, ctrlWriteReg, dataWriteReg,
                             expWriteReg[writesSeen], expWriteData[writesSeen]);
                end
            writesSeen++;
        end
        if (rstN && wren) begin
            assert (storesSeen < expStores) else begin
                errorCount++;
                $display("Store to %h at %0t is beyond the expected sequence",
                         addressDmem, $time);
            end
            if (storesSeen < expStores)
                assert (addressDmem == expStoreAddr[storesSeen]
                        && data == expStoreData[storesSeen]) else begin
                    errorCount++;
                    $display("** Error at %0t: store %0d [%h]=%h, expected [%h]=%h", $time,
                             storesSeen, addressDmem, data,
                             expStoreAddr[storesSeen], expStoreData[storesSeen]);
                end
            storesSeen++;
        end
    end

    // Watchdog sized from the program
    initial begin
        wait (programReady);
        repeat (progLen * 3 + 20) @(posedge clock);
        $display("Timeout: the core did not finish the program in %0d cycles",
                 progLen * 3 + 20);
        $display("Errors: %0d, writes %0d of %0d, stores %0d of %0d",
                 errorCount, writesSeen, expWrites, storesSeen, expStores);
        $display("Verification failed");
        $finish;
    end

    initial begin
        clock        = 1'b0;
        rstN         = 1'b0;
        qImem        = '0;
        qDmem        = '0;
        dataReadRegA = '0;
        dataReadRegB = '0;
        void'($urandom(32'hd7db_e48a));
        for (int i = 0; i < imemDepth; i++)
            imem[i] = '0;                         // Past the end reads as no-op
        for (int i = 0; i < 64; i++) begin
            dmem[i]     = fillWord(i);
            modelMem[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            regs[i]      = '0;
            modelRegs[i] = '0;
        end
        buildProgram();
        runModel();
        expWrites    = expWriteReg.size();
        expStores    = expStoreAddr.size();
        programReady = 1'b1;
        repeat (10) @(posedge clock);
        #5 rstN = 1'b1;
        wait (writesSeen >= expWrites && storesSeen >= expStores);
        repeat (8) @(posedge clock);              // Room for stray late writes
        assert (writesSeen == expWrites && storesSeen == expStores) else begin
            errorCount++;
            $display("Write or store count differs from the reference model");
        end
        $display("Errors: %0d, writes %0d of %0d, stores %0d of %0d",
                 errorCount, writesSeen, expWrites, storesSeen, expStores);
        if (errorCount == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- pipelineCore.f
+incdir+.
isaPkg.sv
pipePkg.sv
fetchUnit.sv
decodeUnit.sv
hazardUnit.sv
executeUnit.sv
resultUnit.sv
pipelineCore.sv
tbPipelineCore.sv

//--- Makefile
TOP = tbPipelineCore

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f pipelineCore.f --top-module $(TOP)

# Pass only when the simulation prints the pass message
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

lint:
	verilator --lint-only -Wall --timing -f pipelineCore.f --top-module pipelineCore

clean:
	rm -rf obj_dir
